//--- logic/aluOpPkg.sv
`default_nettype none

package aluOpPkg;

  // ARM data-processing opcodes, instruction bits 24:21
  typedef enum logic [3:0] {
    opcAnd = 4'h0,
    opcEor = 4'h1,
    opcSub = 4'h2,
    opcRsb = 4'h3,
    opcAdd = 4'h4,
    opcAdc = 4'h5,
    opcSbc = 4'h6,
    opcRsc = 4'h7,
    opcTst = 4'h8,
    opcTeq = 4'h9,
    opcCmp = 4'hA,
    opcCmn = 4'hB,
    opcOrr = 4'hC,
    opcMov = 4'hD,
    opcBic = 4'hE,
    opcMvn = 4'hF
  } aluOpcodeE;

  // Function select of the ALU result mux
  typedef enum logic [2:0] {
    opAnd   = 3'b000,
    opXor   = 3'b001,
    opSum   = 3'b010,
    opOr    = 3'b011,
    opPassB = 3'b100
  } aluOperationE;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } nzcvS;

  typedef struct packed {
    aluOperationE operation;
    logic         invertB;        // Complement B after the swap
    logic         reverseInputs;  // Swap A and B, for RSB and RSC
    logic         carryIn;
  } aluCtrlS;

  typedef struct packed {
    logic updateNz;
    logic updateC;
    logic updateV;
  } flagCtrlS;

endpackage

`default_nettype wire

//--- logic/execIfPkg.sv
`default_nettype none

package execIfPkg;

  // Queue entries, also the credits held upstream after reset
  localparam int QueueDepth = 4;

  // Credits for the output channel after reset
  localparam int OutCredits = 2;

  // Wide enough for either credit count, including the full value
  localparam int CreditWidth =
    $clog2(((QueueDepth > OutCredits) ? QueueDepth : OutCredits) + 1);

  localparam int QueuePtrWidth = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;

  // One data-processing instruction, 69 bits
  typedef struct packed {
    aluOpPkg::aluOpcodeE opcode;
    logic                setFlags;
    logic [31:0]         a;
    logic [31:0]         b;
  } instrS;

  // Result word sent downstream, 37 bits
  typedef struct packed {
    logic [31:0]     value;
    logic            writeReg;   // Low for TST, TEQ, CMP, CMN
    aluOpPkg::nzcvS  flags;      // NZCV after this instruction
  } resultS;

endpackage

`default_nettype wire

//--- logic/aluDecoder.sv
`default_nettype none

module aluDecoder (
  input  aluOpPkg::aluOpcodeE opcode,
  input  logic                setFlags,
  input  logic                carryFlag,
  output aluOpPkg::aluCtrlS   aluCtrl,
  output aluOpPkg::flagCtrlS  flagCtrl,
  output logic                writeReg
);

  import aluOpPkg::*;

  logic arithOp;  // Opcode goes through the adder

  always_comb begin
    aluCtrl.operation     = opSum;
    aluCtrl.invertB       = 1'b0;
    aluCtrl.reverseInputs = 1'b0;
    aluCtrl.carryIn       = 1'b0;
    arithOp               = 1'b0;
    unique case (opcode)
      opcAnd, opcTst: aluCtrl.operation = opAnd;
      opcEor, opcTeq: aluCtrl.operation = opXor;
      opcSub, opcCmp: begin
        aluCtrl.invertB = 1'b1;          // a + ~b + 1
        aluCtrl.carryIn = 1'b1;
        arithOp         = 1'b1;
      end
      opcRsb: begin
        aluCtrl.reverseInputs = 1'b1;    // b + ~a + 1
        aluCtrl.invertB       = 1'b1;
        aluCtrl.carryIn       = 1'b1;
        arithOp               = 1'b1;
      end
      opcAdd, opcCmn: arithOp = 1'b1;
      opcAdc: begin
        aluCtrl.carryIn = carryFlag;
        arithOp         = 1'b1;
      end
      opcSbc: begin
        aluCtrl.invertB = 1'b1;
        aluCtrl.carryIn = carryFlag;     // Borrow taken from C
        arithOp         = 1'b1;
      end
      opcRsc: begin
        aluCtrl.reverseInputs = 1'b1;
        aluCtrl.invertB       = 1'b1;
        aluCtrl.carryIn       = carryFlag;
        arithOp               = 1'b1;
      end
      opcOrr: aluCtrl.operation = opOr;
      opcMov: aluCtrl.operation = opPassB;
      opcBic: begin
        aluCtrl.operation = opAnd;       // a & ~b
        aluCtrl.invertB   = 1'b1;
      end
      opcMvn: begin
        aluCtrl.operation = opPassB;     // ~b
        aluCtrl.invertB   = 1'b1;
      end
    endcase
  end

  // N and Z always follow the result, C and V only for adder opcodes
  assign flagCtrl.updateNz = setFlags;
  assign flagCtrl.updateC  = setFlags & arithOp;
  assign flagCtrl.updateV  = setFlags & arithOp;

  // Compares and tests only set flags
  assign writeReg = !(opcode inside {opcTst, opcTeq, opcCmp, opcCmn});

endmodule

`default_nettype wire

//--- logic/aluCore.sv
`default_nettype none

module aluCore (
  input  logic [31:0]       a,
  input  logic [31:0]       b,
  input  aluOpPkg::aluCtrlS aluCtrl,
  output logic [31:0]       value,
  output aluOpPkg::nzcvS    rawFlags
);

  import aluOpPkg::*;

  logic [31:0] srcA;
  logic [31:0] srcBRaw;
  logic [31:0] srcB;
  logic [32:0] sum;       // Bit 32 is the carry-out
  logic        overflow;

  // Operand steering for the reversed and inverted forms
  always_comb begin
    if (aluCtrl.reverseInputs) begin
      srcA    = b;
      srcBRaw = a;
    end else begin
      srcA    = a;
      srcBRaw = b;
    end
    srcB = aluCtrl.invertB ? ~srcBRaw : srcBRaw;
  end

  assign sum = {1'b0, srcA} + {1'b0, srcB} + {32'd0, aluCtrl.carryIn};

  // Same operand signs but a different result sign
  assign overflow = (srcA[31] == srcB[31]) && (sum[31] != srcA[31]);

  always_comb begin
    case (aluCtrl.operation)
      opAnd:   value = srcA & srcB;
      opXor:   value = srcA ^ srcB;
      opSum:   value = sum[31:0];
      opOr:    value = srcA | srcB;
      opPassB: value = srcB;
      default: value = sum[31:0];
    endcase
  end

  always_comb begin
    rawFlags.n = value[31];
    rawFlags.z = (value == 32'd0);
    rawFlags.c = sum[32];     // Not-borrow for the subtracting forms
    rawFlags.v = overflow;
  end

endmodule

`default_nettype wire

//--- logic/flagRegister.sv
`default_nettype none

module flagRegister (
  input  logic               clk,
  input  logic               rst,
  input  logic               update,
  input  aluOpPkg::flagCtrlS flagCtrl,
  input  aluOpPkg::nzcvS     rawFlags,
  output aluOpPkg::nzcvS     flags
);

  // Each field is replaced only when its control bit is set
  always_ff @(posedge clk) begin
    if (rst) begin
      flags <= '0;
    end else if (update) begin
      if (flagCtrl.updateNz) begin
        flags.n <= rawFlags.n;
        flags.z <= rawFlags.z;
      end
      if (flagCtrl.updateC) begin
        flags.c <= rawFlags.c;
      end
      if (flagCtrl.updateV) begin
        flags.v <= rawFlags.v;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/instrQueue.sv
`default_nettype none

module instrQueue (
  input  logic             clk,
  input  logic             rst,
  input  logic             inValid,
  input  execIfPkg::instrS inInstr,
  input  logic             deq,
  output execIfPkg::instrS head,
  output logic             notEmpty,
  output logic             creditReturn
);

  import execIfPkg::*;

  instrS                    mem [QueueDepth];
  logic [QueuePtrWidth-1:0] wrPtr;
  logic [QueuePtrWidth-1:0] rdPtr;
  logic [CreditWidth-1:0]   count;
  logic                     full;
  logic                     doWrite;
  logic                     doRead;

  assign full     = (count == CreditWidth'(QueueDepth));
  assign notEmpty = (count != '0);
  assign doWrite  = inValid && !full;   // Upstream credits keep this from dropping
  assign doRead   = deq && notEmpty;
  assign head     = mem[rdPtr];

  always_ff @(posedge clk) begin
    if (doWrite) begin
      mem[wrPtr] <= inInstr;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wrPtr        <= '0;
      rdPtr        <= '0;
      count        <= '0;
      creditReturn <= 1'b0;
    end else begin
      if (doWrite) begin
        wrPtr <= (wrPtr == QueuePtrWidth'(QueueDepth - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (doRead) begin
        rdPtr <= (rdPtr == QueuePtrWidth'(QueueDepth - 1)) ? '0 : rdPtr + 1'b1;
      end
      count        <= count + CreditWidth'(doWrite) - CreditWidth'(doRead);
      creditReturn <= doRead;     // One credit back per dequeue
    end
  end

endmodule

`default_nettype wire

//--- logic/executeUnit.sv
`default_nettype none

module executeUnit (
  input  logic              clk,
  input  logic              rst,
  input  logic              inValid,
  input  execIfPkg::instrS  inInstr,
  output logic              creditReturn,
  output logic              outValid,
  output execIfPkg::resultS outResult,
  input  logic              outCreditReturn
);

  import aluOpPkg::*;
  import execIfPkg::*;

  instrS                  headInstr;
  logic                   notEmpty;
  logic                   issue;
  logic [CreditWidth-1:0] outCredits;
  aluCtrlS                aluCtrl;
  flagCtrlS               flagCtrl;
  nzcvS                   rawFlags;
  nzcvS                   flags;
  logic [31:0]            aluValue;
  logic                   decWriteReg;
  logic [31:0]            valueReg;
  logic                   writeRegReg;

  assign issue = notEmpty && (outCredits != '0);

  instrQueue instrQueue_i (
    .clk          (clk),
    .rst          (rst),
    .inValid      (inValid),
    .inInstr      (inInstr),
    .deq          (issue),
    .head         (headInstr),
    .notEmpty     (notEmpty),
    .creditReturn (creditReturn)
  );

  aluDecoder aluDecoder_i (
    .opcode    (headInstr.opcode),
    .setFlags  (headInstr.setFlags),
    .carryFlag (flags.c),
    .aluCtrl   (aluCtrl),
    .flagCtrl  (flagCtrl),
    .writeReg  (decWriteReg)
  );

  aluCore aluCore_i (
    .a        (headInstr.a),
    .b        (headInstr.b),
    .aluCtrl  (aluCtrl),
    .value    (aluValue),
    .rawFlags (rawFlags)
  );

  flagRegister flagRegister_i (
    .clk      (clk),
    .rst      (rst),
    .update   (issue),
    .flagCtrl (flagCtrl),
    .rawFlags (rawFlags),
    .flags    (flags)
  );

  // Credit is taken at issue, outValid follows one cycle later
  always_ff @(posedge clk) begin
    if (rst) begin
      outCredits <= CreditWidth'(OutCredits);
      outValid   <= 1'b0;
    end else begin
      outCredits <= outCredits - CreditWidth'(issue) + CreditWidth'(outCreditReturn);
      outValid   <= issue;
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      valueReg    <= aluValue;
      writeRegReg <= decWriteReg;
    end
  end

  // Flag register loads on the same edge, so it holds the post-instruction NZCV
  assign outResult = '{value: valueReg, writeReg: writeRegReg, flags: flags};

endmodule

`default_nettype wire

//--- testbench/executeUnit_checker.sv
`default_nettype none

module executeUnit_checker (
  input logic              clk,
  input logic              rst,
  input logic              inValid,
  input execIfPkg::instrS  inInstr,
  input logic              creditReturn,
  input logic              outValid,
  input execIfPkg::resultS outResult,
  input logic              outCreditReturn
);

  timeunit 1ns;
  timeprecision 1ps;

  import aluOpPkg::*;
  import execIfPkg::*;

  instrS  shadowMem [16];   // Accepted but not yet answered
  int     wrIdx;
  int     rdIdx;
  nzcvS   shadowFlags;
  resultS expResult;
  int     acceptedCnt;
  int     creditCnt;
  int     outValidCnt;
  int     outCreditCnt;
  int     errorCount = 0;

  // Returns {v, c, sum}
  function automatic logic [33:0] addCarry(input logic [31:0] x, input logic [31:0] y,
                                           input logic cin);
    logic [32:0] s;
    s = {1'b0, x} + {1'b0, y} + {32'd0, cin};
    return {s[32] ^ x[31] ^ y[31] ^ s[31], s};   // Carry into bit 31 xor carry out
  endfunction

  function automatic resultS modelResult(input instrS ins, input nzcvS prev);
    logic [33:0] t;
    logic        arith;
    resultS      r;
    t       = '0;
    r.value = '0;
    arith   = !(ins.opcode inside {opcAnd, opcEor, opcTst, opcTeq, opcOrr, opcMov, opcBic,
                                   opcMvn});
    case (ins.opcode)
      opcAnd, opcTst: r.value = ins.a & ins.b;
      opcEor, opcTeq: r.value = ins.a ^ ins.b;
      opcSub, opcCmp: t = addCarry(ins.a, ~ins.b, 1'b1);
      opcRsb:         t = addCarry(ins.b, ~ins.a, 1'b1);
      opcAdd, opcCmn: t = addCarry(ins.a, ins.b, 1'b0);
      opcAdc:         t = addCarry(ins.a, ins.b, prev.c);
      opcSbc:         t = addCarry(ins.a, ~ins.b, prev.c);
      opcRsc:         t = addCarry(ins.b, ~ins.a, prev.c);
      opcOrr:         r.value = ins.a | ins.b;
      opcMov:         r.value = ins.b;
      opcBic:         r.value = ins.a & ~ins.b;
      default:        r.value = ~ins.b;   // MVN
    endcase
    if (arith) begin
      r.value = t[31:0];
    end
    r.writeReg = (ins.opcode[3:2] != 2'b10);   // Opcodes 8 to 11 write no register
    r.flags    = prev;
    if (ins.setFlags) begin
      r.flags.n = r.value[31];
      r.flags.z = (r.value == 32'd0);
      if (arith) begin
        r.flags.c = t[32];
        r.flags.v = t[33];
      end
    end
    return r;
  endfunction

  always_comb expResult = modelResult(shadowMem[rdIdx[3:0]], shadowFlags);

  always_ff @(posedge clk) begin
    if (rst) begin
      wrIdx        <= 0;
      rdIdx        <= 0;
      shadowFlags  <= '0;
      acceptedCnt  <= 0;
      creditCnt    <= 0;
      outValidCnt  <= 0;
      outCreditCnt <= 0;
    end else begin
      if (inValid) begin
        shadowMem[wrIdx[3:0]] <= inInstr;
        wrIdx                 <= wrIdx + 1;
        acceptedCnt           <= acceptedCnt + 1;
      end
      if (outValid) begin
        rdIdx       <= rdIdx + 1;
        shadowFlags <= expResult.flags;   // Carry seen by the next instruction
        outValidCnt <= outValidCnt + 1;
      end
      if (creditReturn) begin
        creditCnt <= creditCnt + 1;
      end
      if (outCreditReturn) begin
        outCreditCnt <= outCreditCnt + 1;
      end
    end
  end

  assert property (@(posedge clk) disable iff (rst) outValid |-> (wrIdx != rdIdx))
    else begin
      errorCount = errorCount + 1;
      $error("outValid with no accepted instruction outstanding");
    end

  assert property (@(posedge clk) disable iff (rst)
                   outValid |-> (outResult.value == expResult.value))
    else begin
      errorCount = errorCount + 1;
      $error("mismatch outResult.value exp %h got %h", $sampled(expResult.value),
             $sampled(outResult.value));
    end

  assert property (@(posedge clk) disable iff (rst)
                   outValid |-> (outResult.flags == expResult.flags))
    else begin
      errorCount = errorCount + 1;
      $error("mismatch outResult.flags exp %h got %h", $sampled(expResult.flags),
             $sampled(outResult.flags));
    end

  assert property (@(posedge clk) disable iff (rst)
                   outValid |-> (outResult.writeReg == expResult.writeReg))
    else begin
      errorCount = errorCount + 1;
      $error("mismatch outResult.writeReg exp %h got %h", $sampled(expResult.writeReg),
             $sampled(outResult.writeReg));
    end

  assert property (@(posedge clk) disable iff (rst) creditReturn |-> (creditCnt < acceptedCnt))
    else begin
      errorCount = errorCount + 1;
      $error("creditReturn pulse without a matching accepted instruction");
    end

  assert property (@(posedge clk) disable iff (rst)
                   outValid |-> (outValidCnt < OutCredits + outCreditCnt))
    else begin
      errorCount = errorCount + 1;
      $error("more outValid cycles than output credits allow");
    end

  // A credit returned in this cycle may be spent in the same cycle
  assert property (@(posedge clk) disable iff (rst)
                   inValid |-> (acceptedCnt - creditCnt - int'(creditReturn) < QueueDepth))
    else begin
      errorCount = errorCount + 1;
      $error("inValid sent without an input credit");
    end

  assert property (@(posedge clk) $past(rst) |-> (!outValid && !creditReturn))
    else begin
      errorCount = errorCount + 1;
      $error("outValid or creditReturn high during or right after reset");
    end

endmodule

`default_nettype wire

//--- testbench/executeUnitTb.sv
`default_nettype none

module executeUnitTb;

  timeunit 1ns;
  timeprecision 1ps;

  import aluOpPkg::*;
  import execIfPkg::*;

  localparam int Phase1Count   = 300;
  localparam int Phase2Count   = 100;
  localparam int TimeoutCycles = (Phase1Count + Phase2Count) * 8 + 200;
  localparam int DriveDelay    = 10;

  logic   clk;
  logic   rst;
  logic   inValid;
  instrS  inInstr;
  logic   creditReturn;
  logic   outValid;
  resultS outResult;
  logic   outCreditReturn;

  logic [31:0] rngState = 32'h2093_42ca;
  int          inCredits;
  int          owedCredits;   // Results taken but credit not yet given back
  int          holdCycles;
  bit          slowCredits;
  int          sentCount;
  int          doneCount;
  int          errors;

  executeUnit executeUnit_i (.*);

  bind executeUnit executeUnit_checker executeUnit_checker_i (.*);

  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  function automatic logic [31:0] nextRandom();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  // Corner values about half the time
  function automatic logic [31:0] pickOperand();
    logic [31:0] r;
    r = nextRandom();
    case (r[2:0])
      3'd0:    return 32'h0000_0000;
      3'd1:    return 32'hFFFF_FFFF;
      3'd2:    return 32'h8000_0000;
      3'd3:    return 32'h7FFF_FFFF;
      default: return nextRandom();
    endcase
  endfunction

  // Advances one clock and plays the downstream side
  task automatic stepCycle();
    @(posedge clk);
    #DriveDelay;
    inValid         = 1'b0;
    outCreditReturn = 1'b0;
    if (creditReturn) begin
      inCredits++;
    end
    if (outValid) begin
      doneCount++;
      owedCredits++;
    end
    if (holdCycles > 0) begin
      holdCycles--;   // Back-pressure stretch
    end else if (owedCredits > 0) begin
      outCreditReturn = 1'b1;
      owedCredits--;
      if (slowCredits && ((nextRandom() & 32'h7) == 32'h0)) begin
        holdCycles = 4 + int'(nextRandom() & 32'hF);
      end
    end
  endtask

  task automatic sendInstr();
    logic [31:0] r;
    while (inCredits == 0) begin
      stepCycle();
    end
    r                = nextRandom();
    inInstr.opcode   = aluOpcodeE'(r[3:0]);
    inInstr.setFlags = (r[5:4] != 2'b00);   // Mostly set, for carry chains
    inInstr.a        = pickOperand();
    inInstr.b        = pickOperand();
    inValid          = 1'b1;
    inCredits--;
    sentCount++;
    stepCycle();
  endtask

  initial begin
    rst             = 1'b1;
    inValid         = 1'b0;
    inInstr         = '0;
    outCreditReturn = 1'b0;
    inCredits       = QueueDepth;
    owedCredits     = 0;
    holdCycles      = 0;
    slowCredits     = 1'b0;
    sentCount       = 0;
    doneCount       = 0;
    repeat (16) @(posedge clk);
    #DriveDelay;
    rst = 1'b0;
    for (int i = 0; i < Phase1Count; i++) begin
      if ((nextRandom() & 32'h7) == 32'h0) begin
        stepCycle();   // Idle gap
      end
      sendInstr();
    end
    slowCredits = 1'b1;
    for (int i = 0; i < Phase2Count; i++) begin
      sendInstr();
    end
    slowCredits = 1'b0;
    while (doneCount < sentCount) begin
      stepCycle();
    end
    repeat (4) stepCycle();   // Any extra result shows up here
    errors = executeUnit_i.executeUnit_checker_i.errorCount;
    if (doneCount != sentCount) begin
      $display("%0d results seen for %0d instructions sent", doneCount, sentCount);
      errors++;
    end
    $display("errors %0d, instructions sent %0d, results %0d", errors, sentCount, doneCount);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  initial begin
    repeat (TimeoutCycles) @(posedge clk);
    $display("timeout after %0d cycles with %0d of %0d results seen", TimeoutCycles,
             doneCount, sentCount);
    $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
logic/aluOpPkg.sv
logic/execIfPkg.sv
logic/aluDecoder.sv
logic/aluCore.sv
logic/flagRegister.sv
logic/instrQueue.sv
logic/executeUnit.sv
testbench/executeUnit_checker.sv
testbench/executeUnitTb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing --assert -Wno-fatal --top-module executeUnitTb \
  -f vlog.f -Mdir obj_dir -o simExecuteUnit > build.log 2>&1 &&
./obj_dir/simExecuteUnit +verilator+error+limit+1000 > sim.log 2>&1
grep -q "^TEST PASS$" sim.log && echo "simulation passed" ||
  { echo "simulation failed, see build.log and sim.log"; exit 1; }
